/* common/bmc_bus_pkg.sv */
package bmc_bus_pkg;

  // AXI4-Lite side
  localparam int AXIL_ADDR_W = 14;  // byte address
  localparam int AXIL_DATA_W = 32;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [1:0]             axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // internal register bus
  localparam int REG_W      = 16;
  localparam int REG_ADDR_W = AXIL_ADDR_W - 2;  // word address

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_W-1:0]      reg_data_t;

  // region map, each region is 0x40 words
  localparam int REGION_OFFS_W = 6;
  typedef logic [REGION_OFFS_W-1:0] reg_offs_t;

  localparam reg_addr_t SYS_BASE = 12'h000;
  localparam reg_addr_t LC_BASE  = 12'h100;
  localparam reg_addr_t IRQ_BASE = 12'h200;

  localparam int NUM_BLOCKS = 3;
  localparam int SEL_SYS    = 0;
  localparam int SEL_LC     = 1;
  localparam int SEL_IRQ    = 2;

  typedef logic [NUM_BLOCKS-1:0] block_sel_t;  // one-hot

  localparam reg_addr_t [NUM_BLOCKS-1:0] BLOCK_BASE = {IRQ_BASE, LC_BASE, SYS_BASE};

  // register offsets inside a region
  localparam reg_offs_t SYS_ID_OFFS     = 6'h00;
  localparam reg_offs_t SYS_REV_OFFS    = 6'h01;
  localparam reg_offs_t SYS_CFG_OFFS    = 6'h02;
  localparam reg_offs_t LC_INRANGE_OFFS = 6'h20;
  localparam reg_offs_t LC_HCLR_OFFS    = 6'h21;
  localparam reg_offs_t IRQ_PEND_OFFS   = 6'h00;
  localparam reg_offs_t IRQ_MASK_OFFS   = 6'h01;

endpackage

/* common/bmc_mon_pkg.sv */
package bmc_mon_pkg;

  // ADC sample stream
  localparam int ADC_W  = 12;
  localparam int CHAN_W = 5;

  typedef logic [ADC_W-1:0]  adc_sample_t;
  typedef logic [CHAN_W-1:0] adc_chan_t;

  // interrupt sources
  localparam int IRQ_SOFT   = 0;  // soft threshold crossed
  localparam int IRQ_HARD   = 1;  // hard violation raised
  localparam int IRQ_DECODE = 2;  // unmapped bus access
  localparam int NUM_IRQ    = 3;

  typedef logic [NUM_IRQ-1:0] irq_vec_t;

endpackage

/* common/reg_bus_if.sv */
`timescale 1ns/1ps

interface reg_bus_if;
  import bmc_bus_pkg::*;

  block_sel_t sel;    // one cycle per access
  logic       we;
  reg_addr_t  addr;
  reg_data_t  wdata;

  // one return path per block
  reg_data_t  sys_rdata;
  logic       sys_ack;
  reg_data_t  lc_rdata;
  logic       lc_ack;
  reg_data_t  irq_rdata;
  logic       irq_ack;

  modport ctrl (
    output sel, we, addr, wdata,
    input  sys_rdata, sys_ack, lc_rdata, lc_ack, irq_rdata, irq_ack
  );
  modport sys_blk (input sel, we, addr, wdata, output sys_rdata, sys_ack);
  modport lc_blk  (input sel, we, addr, wdata, output lc_rdata, lc_ack);
  modport irq_blk (input sel, we, addr, wdata, output irq_rdata, irq_ack);

endinterface

/* design/axil_reg_ctrl.sv */
`timescale 1ns/1ps

module axil_reg_ctrl (
  input  logic                    gclk40,
  input  logic                    reset_i,
  input  bmc_bus_pkg::axil_addr_t s_axil_awaddr_i,
  input  logic                    s_axil_awvalid_i,
  output logic                    s_axil_awready_o,
  input  bmc_bus_pkg::axil_data_t s_axil_wdata_i,
  input  logic                    s_axil_wvalid_i,
  output logic                    s_axil_wready_o,
  output bmc_bus_pkg::axil_resp_t s_axil_bresp_o,
  output logic                    s_axil_bvalid_o,
  input  logic                    s_axil_bready_i,
  input  bmc_bus_pkg::axil_addr_t s_axil_araddr_i,
  input  logic                    s_axil_arvalid_i,
  output logic                    s_axil_arready_o,
  output bmc_bus_pkg::axil_data_t s_axil_rdata_o,
  output bmc_bus_pkg::axil_resp_t s_axil_rresp_o,
  output logic                    s_axil_rvalid_o,
  input  logic                    s_axil_rready_i,
  reg_bus_if.ctrl                 bus,
  output logic                    decode_err_o
);
  import bmc_bus_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_SEL, ST_ACK, ST_BRESP, ST_RRESP} state_t;

  state_t     state;
  logic       wr_go;
  logic       rd_go;
  logic       any_ack;
  reg_addr_t  acc_addr;
  block_sel_t acc_sel;
  block_sel_t sel_q;
  logic       we_q;
  reg_addr_t  addr_q;
  reg_data_t  wdata_q;
  reg_data_t  ack_rdata;
  reg_data_t  rdata_q;
  axil_resp_t resp_q;

  // region hit on the upper word-address bits
  function automatic block_sel_t decode_sel(input reg_addr_t a);
    block_sel_t s;
    s = '0;
    for (int i = 0; i < NUM_BLOCKS; i++) begin
      if ((a >> REGION_OFFS_W) == (BLOCK_BASE[i] >> REGION_OFFS_W))
        s[i] = 1'b1;
    end
    return s;
  endfunction

  assign wr_go = (state == ST_IDLE) && s_axil_awvalid_i && s_axil_wvalid_i;
  assign rd_go = (state == ST_IDLE) && s_axil_arvalid_i && !wr_go;  // write wins

  assign s_axil_awready_o = wr_go;
  assign s_axil_wready_o  = wr_go;
  assign s_axil_arready_o = rd_go;

  assign acc_addr = wr_go ? s_axil_awaddr_i[AXIL_ADDR_W-1:2] : s_axil_araddr_i[AXIL_ADDR_W-1:2];
  assign acc_sel  = decode_sel(acc_addr);

  assign any_ack   = bus.sys_ack | bus.lc_ack | bus.irq_ack;
  assign ack_rdata = ({REG_W{bus.sys_ack}} & bus.sys_rdata)
                   | ({REG_W{bus.lc_ack}}  & bus.lc_rdata)
                   | ({REG_W{bus.irq_ack}} & bus.irq_rdata);

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      state        <= ST_IDLE;
      sel_q        <= '0;
      decode_err_o <= 1'b0;
    end else begin
      sel_q        <= '0;  // select lasts a single cycle
      decode_err_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (wr_go || rd_go) begin
            if (|acc_sel) begin
              sel_q <= acc_sel;
              state <= ST_SEL;
            end else begin
              decode_err_o <= 1'b1;  // answer directly with SLVERR
              state        <= wr_go ? ST_BRESP : ST_RRESP;
            end
          end
        end
        ST_SEL:   state <= ST_ACK;
        ST_ACK:   if (any_ack) state <= we_q ? ST_BRESP : ST_RRESP;
        ST_BRESP: if (s_axil_bready_i) state <= ST_IDLE;
        ST_RRESP: if (s_axil_rready_i) state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge gclk40) begin
    if (wr_go || rd_go) begin
      we_q    <= wr_go;
      addr_q  <= acc_addr;
      wdata_q <= s_axil_wdata_i[REG_W-1:0];  // upper half dropped
      resp_q  <= (|acc_sel) ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= '0;
    end else if (state == ST_ACK && any_ack) begin
      rdata_q <= ack_rdata;
    end
  end

  assign bus.sel   = sel_q;
  assign bus.we    = we_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

  assign s_axil_bvalid_o = (state == ST_BRESP);
  assign s_axil_rvalid_o = (state == ST_RRESP);
  assign s_axil_bresp_o  = resp_q;
  assign s_axil_rresp_o  = resp_q;
  assign s_axil_rdata_o  = {{(AXIL_DATA_W-REG_W){1'b0}}, rdata_q};

  a_bvalid_hold: assert property (@(posedge gclk40) disable iff (reset_i)
    s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

  a_rvalid_hold: assert property (@(posedge gclk40) disable iff (reset_i)
    s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o);

  a_sel_single: assert property (@(posedge gclk40) disable iff (reset_i)
    |bus.sel |=> !(|bus.sel));

endmodule

/* design/sys_config_regs.sv */
`timescale 1ns/1ps

module sys_config_regs #(
  parameter bmc_bus_pkg::reg_data_t BOARD_ID           = 16'h0000,
  parameter bmc_bus_pkg::reg_data_t REVISION           = 16'h0000,
  parameter logic [7:0]             DEFAULT_SYS_CONFIG = 8'h00
) (
  input  logic       gclk40,
  input  logic       reset_i,
  reg_bus_if.sys_blk bus,
  output logic [7:0] sys_config_o
);
  import bmc_bus_pkg::*;

  logic      sel;
  reg_offs_t offs;

  assign sel  = bus.sel[SEL_SYS];
  assign offs = bus.addr[REGION_OFFS_W-1:0];

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      sys_config_o <= DEFAULT_SYS_CONFIG;
      bus.sys_ack  <= 1'b0;
    end else begin
      bus.sys_ack <= sel;
      if (sel && bus.we && offs == SYS_CFG_OFFS)
        sys_config_o <= bus.wdata[7:0];  // id and revision ignore writes
    end
  end

  always_ff @(posedge gclk40) begin
    if (sel) begin
      case (offs)
        SYS_ID_OFFS:  bus.sys_rdata <= BOARD_ID;
        SYS_REV_OFFS: bus.sys_rdata <= REVISION;
        SYS_CFG_OFFS: bus.sys_rdata <= {8'h00, sys_config_o};
        default:      bus.sys_rdata <= '0;
      endcase
    end
  end

endmodule

/* level_checker/level_checker.sv */
`timescale 1ns/1ps

module level_checker #(
  parameter int NUM_CHANNELS = 8
) (
  input  logic                     gclk40,
  input  logic                     reset_i,
  reg_bus_if.lc_blk                bus,
  input  logic                     adc_strb_i,
  input  bmc_mon_pkg::adc_chan_t   adc_channel_i,
  input  bmc_mon_pkg::adc_sample_t adc_result_i,
  output logic                     soft_viol_o,
  output logic [NUM_CHANNELS-1:0]  v_in_range_o,
  output logic                     hard_viol_o
);
  import bmc_bus_pkg::*;
  import bmc_mon_pkg::*;

  localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

  adc_sample_t      soft_thr [NUM_CHANNELS];
  adc_sample_t      hard_thr [NUM_CHANNELS];
  logic             sel;
  reg_offs_t        offs;
  logic             thr_hit;
  logic [IDX_W-1:0] thr_ch;
  logic [IDX_W-1:0] smp_ch;
  logic             smp_ok;
  logic             over_soft;
  logic             over_hard;
  reg_data_t        rd_next;

  assign sel     = bus.sel[SEL_LC];
  assign offs    = bus.addr[REGION_OFFS_W-1:0];
  assign thr_hit = int'(offs) < 2 * NUM_CHANNELS;  // soft/hard pairs from offset 0
  assign thr_ch  = offs[IDX_W:1];

  assign smp_ok    = adc_strb_i && (int'(adc_channel_i) < NUM_CHANNELS);
  assign smp_ch    = adc_channel_i[IDX_W-1:0];
  assign over_soft = adc_result_i > soft_thr[smp_ch];
  assign over_hard = adc_result_i > hard_thr[smp_ch];

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        soft_thr[i] <= '1;
        hard_thr[i] <= '1;
      end
    end else if (sel && bus.we && thr_hit) begin
      if (offs[0])
        hard_thr[thr_ch] <= bus.wdata[ADC_W-1:0];
      else
        soft_thr[thr_ch] <= bus.wdata[ADC_W-1:0];
    end
  end

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      v_in_range_o <= '1;
      soft_viol_o  <= 1'b0;
      hard_viol_o  <= 1'b0;
      bus.lc_ack   <= 1'b0;
    end else begin
      bus.lc_ack  <= sel;
      soft_viol_o <= smp_ok && over_soft;  // one-cycle pulse
      if (smp_ok)
        v_in_range_o[smp_ch] <= !over_soft;
      // a new violation beats a clear in the same cycle
      if (smp_ok && over_hard)
        hard_viol_o <= 1'b1;
      else if (sel && bus.we && offs == LC_HCLR_OFFS)
        hard_viol_o <= 1'b0;
    end
  end

  always_comb begin
    rd_next = '0;
    if (thr_hit)
      rd_next[ADC_W-1:0] = offs[0] ? hard_thr[thr_ch] : soft_thr[thr_ch];
    else if (offs == LC_INRANGE_OFFS)
      rd_next[NUM_CHANNELS-1:0] = v_in_range_o;
  end

  always_ff @(posedge gclk40) begin
    if (sel) bus.lc_rdata <= rd_next;
  end

  a_bad_chan_ignored: assert property (@(posedge gclk40) disable iff (reset_i)
    adc_strb_i && (int'(adc_channel_i) >= NUM_CHANNELS) |=> $stable(v_in_range_o));

endmodule

/* design/irq_controller.sv */
`timescale 1ns/1ps

module irq_controller (
  input  logic                  gclk40,
  input  logic                  reset_i,
  reg_bus_if.irq_blk            bus,
  input  bmc_mon_pkg::irq_vec_t irq_src_i,
  output logic                  irq_o
);
  import bmc_bus_pkg::*;
  import bmc_mon_pkg::*;

  irq_vec_t  pending;
  irq_vec_t  mask;
  irq_vec_t  src_set;
  irq_vec_t  clr;
  logic      hard_q;
  logic      sel;
  reg_offs_t offs;
  reg_data_t rd_next;

  assign sel  = bus.sel[SEL_IRQ];
  assign offs = bus.addr[REGION_OFFS_W-1:0];

  // hard violation arrives as a sticky level, only its rising edge counts
  always_comb begin
    src_set           = irq_src_i;
    src_set[IRQ_HARD] = irq_src_i[IRQ_HARD] & ~hard_q;
  end

  assign clr = (sel && bus.we && offs == IRQ_PEND_OFFS) ? bus.wdata[NUM_IRQ-1:0] : '0;

  always_ff @(posedge gclk40) begin
    if (reset_i) begin
      pending     <= '0;
      mask        <= '0;
      hard_q      <= 1'b0;
      irq_o       <= 1'b0;
      bus.irq_ack <= 1'b0;
    end else begin
      hard_q      <= irq_src_i[IRQ_HARD];
      bus.irq_ack <= sel;
      pending     <= (pending & ~clr) | src_set;  // new event survives its own clear
      if (sel && bus.we && offs == IRQ_MASK_OFFS)
        mask <= bus.wdata[NUM_IRQ-1:0];
      irq_o <= |(pending & mask);
    end
  end

  always_comb begin
    rd_next = '0;
    if (offs == IRQ_PEND_OFFS)
      rd_next[NUM_IRQ-1:0] = pending;
    else if (offs == IRQ_MASK_OFFS)
      rd_next[NUM_IRQ-1:0] = mask;
  end

  always_ff @(posedge gclk40) begin
    if (sel) bus.irq_rdata <= rd_next;
  end

endmodule

/* design/bmc_top.sv */
`timescale 1ns/1ps

module bmc_top #(
  parameter int                     NUM_CHANNELS       = 8,
  parameter bmc_bus_pkg::reg_data_t BOARD_ID           = 16'hB3C1,
  parameter bmc_bus_pkg::reg_data_t REVISION           = 16'h0201,
  parameter logic [7:0]             DEFAULT_SYS_CONFIG = 8'h5A
) (
  input  logic                     gclk40,
  input  logic                     reset_i,
  input  bmc_bus_pkg::axil_addr_t  s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  bmc_bus_pkg::axil_data_t  s_axil_wdata_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output bmc_bus_pkg::axil_resp_t  s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  logic                     s_axil_bready_i,
  input  bmc_bus_pkg::axil_addr_t  s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output bmc_bus_pkg::axil_data_t  s_axil_rdata_o,
  output bmc_bus_pkg::axil_resp_t  s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  logic                     s_axil_rready_i,
  input  logic                     adc_strb_i,
  input  bmc_mon_pkg::adc_chan_t   adc_channel_i,
  input  bmc_mon_pkg::adc_sample_t adc_result_i,
  output logic [7:0]               sys_config_o,
  output logic [NUM_CHANNELS-1:0]  v_in_range_o,
  output logic                     hard_viol_o,
  output logic                     irq_o
);
  import bmc_mon_pkg::*;

  logic     decode_err;
  logic     soft_viol;
  irq_vec_t irq_src;

  reg_bus_if bus ();

  axil_reg_ctrl u_ctrl (
    .gclk40(gclk40), .reset_i(reset_i),
    .s_axil_awaddr_i(s_axil_awaddr_i), .s_axil_awvalid_i(s_axil_awvalid_i),
    .s_axil_awready_o(s_axil_awready_o),
    .s_axil_wdata_i(s_axil_wdata_i), .s_axil_wvalid_i(s_axil_wvalid_i),
    .s_axil_wready_o(s_axil_wready_o),
    .s_axil_bresp_o(s_axil_bresp_o), .s_axil_bvalid_o(s_axil_bvalid_o),
    .s_axil_bready_i(s_axil_bready_i),
    .s_axil_araddr_i(s_axil_araddr_i), .s_axil_arvalid_i(s_axil_arvalid_i),
    .s_axil_arready_o(s_axil_arready_o),
    .s_axil_rdata_o(s_axil_rdata_o), .s_axil_rresp_o(s_axil_rresp_o),
    .s_axil_rvalid_o(s_axil_rvalid_o), .s_axil_rready_i(s_axil_rready_i),
    .bus(bus.ctrl), .decode_err_o(decode_err)
  );

  sys_config_regs #(
    .BOARD_ID(BOARD_ID), .REVISION(REVISION), .DEFAULT_SYS_CONFIG(DEFAULT_SYS_CONFIG)
  ) u_sys (
    .gclk40(gclk40), .reset_i(reset_i), .bus(bus.sys_blk), .sys_config_o(sys_config_o)
  );

  level_checker #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) u_lc (
    .gclk40(gclk40), .reset_i(reset_i), .bus(bus.lc_blk),
    .adc_strb_i(adc_strb_i), .adc_channel_i(adc_channel_i), .adc_result_i(adc_result_i),
    .soft_viol_o(soft_viol), .v_in_range_o(v_in_range_o), .hard_viol_o(hard_viol_o)
  );

  assign irq_src[IRQ_SOFT]   = soft_viol;
  assign irq_src[IRQ_HARD]   = hard_viol_o;  // edge taken inside the irq block
  assign irq_src[IRQ_DECODE] = decode_err;

  irq_controller u_irq (
    .gclk40(gclk40), .reset_i(reset_i), .bus(bus.irq_blk),
    .irq_src_i(irq_src), .irq_o(irq_o)
  );

endmodule

/* verif/tb_bmc_checks.svh */
`ifndef TB_BMC_CHECKS_SVH
`define TB_BMC_CHECKS_SVH

// one error counter per kind of result
int check_count  = 0;
int reg_errors   = 0;
int resp_errors  = 0;
int flag_errors  = 0;
int other_errors = 0;

// register read data
task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
  check_count++;
  if (act !== exp) begin
    reg_errors++;
    $display("CHECK FAILED at %0t: %s expected 0x%04h, got 0x%04h", $time, name, exp, act);
  end
endtask

// BRESP / RRESP codes
task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
  check_count++;
  if (act !== exp) begin
    resp_errors++;
    $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
  end
endtask

// status pins and maps zero-extended to 16 bits
task automatic check_flag(input string name, input logic [15:0] exp, input logic [15:0] act);
  check_count++;
  if (act !== exp) begin
    flag_errors++;
    $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
  end
endtask

// protocol problems that have no single expected value
task automatic report_failure(input string what);
  other_errors++;
  $display("failure at %0t: %s", $time, what);
endtask

function automatic int total_errors();
  return reg_errors + resp_errors + flag_errors + other_errors;
endfunction

`endif

/* verif/tb_bmc_top.sv */
`timescale 1ns/1ps

module tb_bmc_top;
  import bmc_bus_pkg::*;
  import bmc_mon_pkg::*;

  localparam int          NUM_CH   = 8;
  localparam reg_data_t   BOARD_ID = 16'hB3C1;
  localparam reg_data_t   REVISION = 16'h0201;
  localparam logic [7:0]  DEF_CFG  = 8'h5A;
  localparam int N_CFG = 12;
  localparam int N_SMP = 80;
  localparam int N_IRQ = 10;
  localparam int N_BAD = 12;
  // transactions plus samples with each phase counted generously
  localparam int TB_OPS = 3 + 2 * N_CFG + 2 + 3 * NUM_CH + 3 * N_SMP + 6 * N_IRQ + 3 * N_BAD;
  localparam int WATCHDOG_CYCLES = TB_OPS * 20;

  logic                gclk40;
  logic                reset_i;
  axil_addr_t          awaddr;
  logic                awvalid;
  logic                awready;
  axil_data_t          wdata;
  logic                wvalid;
  logic                wready;
  axil_resp_t          bresp;
  logic                bvalid;
  logic                bready;
  axil_addr_t          araddr;
  logic                arvalid;
  logic                arready;
  axil_data_t          rdata;
  axil_resp_t          rresp;
  logic                rvalid;
  logic                rready;
  logic                adc_strb;
  adc_chan_t           adc_channel;
  adc_sample_t         adc_result;
  logic [7:0]          sys_config;
  logic [NUM_CH-1:0]   v_in_range;
  logic                hard_viol;
  logic                irq;

  // reference model state
  adc_sample_t         soft_thr_m [NUM_CH];
  adc_sample_t         hard_thr_m [NUM_CH];
  logic [NUM_CH-1:0]   inr_m;
  logic                hard_m;
  irq_vec_t            pend_m;
  irq_vec_t            mask_m;
  logic [7:0]          cfg_m;

  `include "tb_bmc_checks.svh"

  bmc_top #(
    .NUM_CHANNELS(NUM_CH), .BOARD_ID(BOARD_ID), .REVISION(REVISION),
    .DEFAULT_SYS_CONFIG(DEF_CFG)
  ) uut (
    .gclk40(gclk40), .reset_i(reset_i),
    .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
    .s_axil_wdata_i(wdata), .s_axil_wvalid_i(wvalid), .s_axil_wready_o(wready),
    .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid), .s_axil_bready_i(bready),
    .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid), .s_axil_arready_o(arready),
    .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp), .s_axil_rvalid_o(rvalid),
    .s_axil_rready_i(rready),
    .adc_strb_i(adc_strb), .adc_channel_i(adc_channel), .adc_result_i(adc_result),
    .sys_config_o(sys_config), .v_in_range_o(v_in_range), .hard_viol_o(hard_viol),
    .irq_o(irq)
  );

  initial begin : clock_gen
    gclk40 = 1'b0;
    forever #50 gclk40 = ~gclk40;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge gclk40);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

  function automatic reg_addr_t reg_at(input reg_addr_t base, input int offs);
    return base + reg_addr_t'(offs);
  endfunction

  // three regions of 0x40 words each
  function automatic bit is_mapped(input reg_addr_t a);
    return (a >= SYS_BASE && a < SYS_BASE + 12'h040) ||
           (a >= LC_BASE  && a < LC_BASE  + 12'h040) ||
           (a >= IRQ_BASE && a < IRQ_BASE + 12'h040);
  endfunction

  function automatic reg_addr_t unmapped_addr();
    reg_addr_t a;
    do a = reg_addr_t'($urandom); while (is_mapped(a));
    return a;
  endfunction

  task automatic axil_write(input reg_addr_t waddr, input reg_data_t data,
                            output axil_resp_t resp);
    logic hs;
    int   stall;
    hs    = 1'b0;
    stall = $urandom_range(0, 3);
    @(negedge gclk40);
    awaddr  = {waddr, 2'b00};
    wdata   = {16'($urandom), data};  // upper half is junk
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!hs) begin
      #1;
      if (awready !== wready) report_failure("AWREADY and WREADY did not pulse together");
      hs = awready && wready;
      @(negedge gclk40);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge gclk40);
    repeat (stall) begin
      @(negedge gclk40);
      if (!bvalid) report_failure("write response dropped before BREADY");
    end
    resp  = bresp;
    bready = 1'b1;
    @(negedge gclk40);
    bready = 1'b0;
    if (bvalid) report_failure("write response repeated after its handshake");
  endtask

  task automatic axil_read(input reg_addr_t raddr, output reg_data_t data,
                           output axil_resp_t resp);
    logic hs;
    int   stall;
    hs    = 1'b0;
    stall = $urandom_range(0, 3);
    @(negedge gclk40);
    araddr  = {raddr, 2'b00};
    arvalid = 1'b1;
    while (!hs) begin
      #1;
      hs = arready;
      @(negedge gclk40);
    end
    arvalid = 1'b0;
    while (!rvalid) @(negedge gclk40);
    repeat (stall) begin
      @(negedge gclk40);
      if (!rvalid) report_failure("read response dropped before RREADY");
    end
    if (rdata[31:16] !== 16'h0000) report_failure("upper half of read data is not zero");
    data   = rdata[15:0];
    resp   = rresp;
    rready = 1'b1;
    @(negedge gclk40);
    rready = 1'b0;
    if (rvalid) report_failure("read response repeated after its handshake");
  endtask

  task automatic model_sample(input adc_chan_t ch, input adc_sample_t val);
    int idx;
    idx = int'(ch);
    if (idx < NUM_CH) begin  // other channels are ignored
      if (val > soft_thr_m[idx]) begin
        inr_m[idx]       = 1'b0;
        pend_m[IRQ_SOFT] = 1'b1;
      end else begin
        inr_m[idx] = 1'b1;
      end
      if (val > hard_thr_m[idx]) begin
        if (!hard_m) pend_m[IRQ_HARD] = 1'b1;  // rising edge only
        hard_m = 1'b1;
      end
    end
  endtask

  task automatic apply_sample(input adc_chan_t ch, input adc_sample_t val);
    @(negedge gclk40);
    adc_strb    = 1'b1;
    adc_channel = ch;
    adc_result  = val;
    @(negedge gclk40);
    adc_strb = 1'b0;
    model_sample(ch, val);
    check_flag("v_in_range_o", 16'(inr_m), 16'(v_in_range));
    check_flag("hard_viol_o", 16'(hard_m), 16'(hard_viol));
  endtask

  // half the samples hit a checked channel
  function automatic adc_chan_t random_channel();
    if ($urandom_range(0, 1) == 1)
      return adc_chan_t'($urandom_range(0, NUM_CH - 1));
    return adc_chan_t'($urandom);
  endfunction

  task automatic check_pending();
    reg_data_t  rd;
    axil_resp_t rsp;
    axil_read(reg_at(IRQ_BASE, 0), rd, rsp);
    check_resp("pending rresp", RESP_OKAY, rsp);
    check_reg("irq pending", reg_data_t'(pend_m), rd);
    check_flag("irq_o", 16'(|(pend_m & mask_m)), 16'(irq));
  endtask

  initial begin : stimulus
    reg_data_t  rd;
    reg_data_t  v;
    axil_resp_t rsp;
    reg_addr_t  bad;
    void'($urandom(32'h32ef));
    reset_i     = 1'b1;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    adc_strb    = 1'b0;
    adc_channel = '0;
    adc_result  = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      soft_thr_m[c] = 12'hFFF;
      hard_thr_m[c] = 12'hFFF;
    end
    inr_m  = '1;
    hard_m = 1'b0;
    pend_m = '0;
    mask_m = '0;
    cfg_m  = DEF_CFG;
    repeat (4) @(posedge gclk40);
    @(negedge gclk40);
    reset_i = 1'b0;

    // state right after reset
    check_flag("sys_config_o", 16'(cfg_m), 16'(sys_config));
    check_flag("irq_o", 16'h0, 16'(irq));
    check_flag("hard_viol_o", 16'h0, 16'(hard_viol));
    check_flag("v_in_range_o", 16'(inr_m), 16'(v_in_range));
    check_flag("s_axil_awready_o", 16'h0, 16'(awready));
    check_flag("s_axil_wready_o", 16'h0, 16'(wready));
    check_flag("s_axil_arready_o", 16'h0, 16'(arready));
    check_flag("s_axil_bvalid_o", 16'h0, 16'(bvalid));
    check_flag("s_axil_rvalid_o", 16'h0, 16'(rvalid));
    axil_read(reg_at(SYS_BASE, 0), rd, rsp);
    check_resp("id rresp", RESP_OKAY, rsp);
    check_reg("board id", BOARD_ID, rd);
    axil_read(reg_at(SYS_BASE, 1), rd, rsp);
    check_resp("rev rresp", RESP_OKAY, rsp);
    check_reg("revision", REVISION, rd);
    axil_read(reg_at(SYS_BASE, 2), rd, rsp);
    check_resp("config rresp", RESP_OKAY, rsp);
    check_reg("config after reset", reg_data_t'(DEF_CFG), rd);

    repeat (N_CFG) begin
      v = 16'($urandom);
      axil_write(reg_at(SYS_BASE, 2), v, rsp);
      check_resp("config bresp", RESP_OKAY, rsp);
      cfg_m = v[7:0];
      axil_read(reg_at(SYS_BASE, 2), rd, rsp);
      check_reg("config readback", reg_data_t'(cfg_m), rd);
      check_flag("sys_config_o", 16'(cfg_m), 16'(sys_config));
    end
    axil_write(reg_at(SYS_BASE, 0), 16'($urandom), rsp);  // read-only
    axil_read(reg_at(SYS_BASE, 0), rd, rsp);
    check_reg("board id after write", BOARD_ID, rd);

    for (int c = 0; c < NUM_CH; c++) begin
      soft_thr_m[c] = 12'($urandom);
      hard_thr_m[c] = 12'($urandom);
      axil_write(reg_at(LC_BASE, 2 * c), 16'(soft_thr_m[c]), rsp);
      check_resp("soft thr bresp", RESP_OKAY, rsp);
      axil_write(reg_at(LC_BASE, 2 * c + 1), 16'(hard_thr_m[c]), rsp);
      axil_read(reg_at(LC_BASE, 2 * c + 1), rd, rsp);
      check_reg("hard thr readback", 16'(hard_thr_m[c]), rd);
    end

    for (int n = 0; n < N_SMP; n++) begin
      apply_sample(random_channel(), adc_sample_t'($urandom));
      axil_read(reg_at(LC_BASE, 'h20), rd, rsp);
      check_resp("in-range rresp", RESP_OKAY, rsp);
      check_reg("in-range map", reg_data_t'(inr_m), rd);
      if (n % 8 == 7) begin
        axil_write(reg_at(LC_BASE, 'h21), 16'($urandom), rsp);  // any value clears
        hard_m = 1'b0;
        check_flag("hard_viol_o after clear", 16'h0, 16'(hard_viol));
      end
    end

    repeat (N_IRQ) begin
      apply_sample(random_channel(), adc_sample_t'($urandom));
      mask_m = irq_vec_t'($urandom);
      axil_write(reg_at(IRQ_BASE, 1), 16'(mask_m), rsp);
      check_resp("mask bresp", RESP_OKAY, rsp);
      check_pending();
      v = 16'($urandom);
      axil_write(reg_at(IRQ_BASE, 0), v, rsp);  // write-1-to-clear
      pend_m = pend_m & ~v[NUM_IRQ-1:0];
      check_pending();
    end

    repeat (N_BAD) begin
      bad = unmapped_addr();
      if ($urandom_range(0, 1) == 1) begin
        axil_write(bad, 16'($urandom), rsp);
      end else begin
        axil_read(bad, rd, rsp);
        check_reg("unmapped rdata", 16'h0000, rd);
      end
      check_resp("unmapped resp", RESP_SLVERR, rsp);
      pend_m[IRQ_DECODE] = 1'b1;
      check_pending();
      axil_write(reg_at(IRQ_BASE, 0), 16'(1 << IRQ_DECODE), rsp);
      pend_m[IRQ_DECODE] = 1'b0;
    end

    $display("summary: %0d checks, %0d reg, %0d resp, %0d flag, %0d other errors",
             check_count, reg_errors, resp_errors, flag_errors, other_errors);
    if (total_errors() == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* sources.f */
+incdir+verif
common/bmc_bus_pkg.sv
common/bmc_mon_pkg.sv
common/reg_bus_if.sv
design/axil_reg_ctrl.sv
design/sys_config_regs.sv
level_checker/level_checker.sv
design/irq_controller.sv
design/bmc_top.sv
verif/tb_bmc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_bmc_top -o tb_bmc_top

./obj_dir/tb_bmc_top | tee sim.log

if grep -qx "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
